// ==== run_sim.sh ====
#!/bin/sh
# Compile the receive buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_rx_buffer_inband \
    -Mdir obj_dir -o tb_rx_buffer_inband
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_rx_buffer_inband > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim.f ====
src/rx_buffer_pkg.sv
src/rx_apb_pkg.sv
src/rx_fifo.sv
src/rx_sample_path.sv
src/rx_cmd_path.sv
src/rx_packet_builder.sv
src/rx_apb_port.sv
src/rx_buffer_inband.sv
verification/rx_buffer_checker.sv
verification/tb_rx_buffer_inband.sv

// ==== src/rx_apb_pkg.sv ====
/* APB request and response structs, register map of the host port */
package rx_apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Register map
    localparam logic [3:0] ADDR_DATA   = 4'h0;
    localparam logic [3:0] ADDR_STATUS = 4'h4;
    localparam logic [3:0] ADDR_CTRL   = 4'h8;

endpackage

// ==== src/rx_apb_port.sv ====
/* APB slave: output FIFO pops, status word, overrun clear */
`timescale 1ns/1ps

module rx_apb_port #(
    parameter int PAYLOAD_WORDS = 8,
    parameter int OUT_DEPTH     = 64
) (
    input  logic                           rxclk,
    input  logic                           reset,
    input  rx_apb_pkg::apb_req_t           apb_req,
    output rx_apb_pkg::apb_rsp_t           apb_rsp,
    input  logic [15:0]                    out_head,
    input  logic [$clog2(OUT_DEPTH):0]     out_level,
    output logic                           out_pop,
    input  logic                           rx_overrun,
    output logic                           clear_overrun,
    output logic                           have_pkt_rdy
);
    import rx_apb_pkg::*;
    import rx_buffer_pkg::*;

    logic         setup;
    logic         access;
    logic [31:0]  status_word;
    logic [31:0]  rd_word;
    logic         rd_err;
    logic [31:0]  prdata_q;
    logic         err_q;

    assign setup  = apb_req.psel & ~apb_req.penable;
    assign access = apb_req.psel & apb_req.penable;

    assign have_pkt_rdy = int'(out_level) >= HDR_WORDS + PAYLOAD_WORDS;
    assign status_word  = {16'h0000, 8'(out_level), 6'b0, rx_overrun, have_pkt_rdy};

    always_comb
    begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (apb_req.paddr)
            ADDR_DATA:
                if (out_level == '0)
                    rd_err = 1'b1;
                else
                    rd_word = {16'h0000, out_head};
            ADDR_STATUS:
                rd_word = status_word;
            default:
                rd_word = '0;
        endcase
    end

    // Read response is prepared in setup and held through access
    always_ff @(posedge rxclk)
    begin
        if (reset)
        begin
            prdata_q <= '0;
            err_q    <= 1'b0;
        end
        else if (setup && !apb_req.pwrite)
        begin
            prdata_q <= rd_word;
            err_q    <= rd_err;
        end
        else
        begin
            prdata_q <= '0;
            err_q    <= 1'b0;
        end
    end

    // No pop if setup saw an empty FIFO
    assign out_pop = access & ~apb_req.pwrite & (apb_req.paddr == ADDR_DATA) & ~err_q;
    assign clear_overrun = access & apb_req.pwrite & (apb_req.paddr == ADDR_CTRL)
                         & apb_req.pwdata[0];

    assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: err_q & access};

endmodule

// ==== src/rx_buffer_inband.sv ====
/* Receive buffer top: sample and command paths, packet builder,
   output FIFO and APB host port */
`timescale 1ns/1ps

module rx_buffer_inband #(
    parameter int PAYLOAD_WORDS = 8,
    parameter int SAMPLE_DEPTH  = 32,
    parameter int CMD_DEPTH     = 16,
    parameter int OUT_DEPTH     = 64
) (
    input  logic                  rxclk,
    input  logic                  reset,
    input  logic                  rxstrobe,
    input  logic [15:0]           ch_0,
    input  logic                  rx_wr,
    input  logic [15:0]           rx_databus,
    input  logic                  rx_wr_done,
    input  rx_apb_pkg::apb_req_t  apb_req,
    output rx_apb_pkg::apb_rsp_t  apb_rsp,
    output logic                  have_pkt_rdy,
    output logic                  rx_overrun,
    output logic                  rx_wr_enabled
);
    import rx_buffer_pkg::*;

    sample_entry_t                    sample_head;
    logic [$clog2(SAMPLE_DEPTH):0]    sample_level;
    logic                             sample_pop;
    logic [15:0]                      adctime;
    logic                             clear_overrun;
    logic                             cmd_ready;
    cmd_word_t                        cmd_head;
    logic [$clog2(CMD_DEPTH):0]       cmd_level;
    logic [15:0]                      cmd_stamp;
    logic                             cmd_pop;
    logic                             out_push;
    logic [15:0]                      out_data;
    logic                             out_pop;
    logic [15:0]                      out_head;
    logic [$clog2(OUT_DEPTH):0]       out_level;

    rx_sample_path #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) u_sample_path (
        .rxclk         (rxclk),
        .reset         (reset),
        .rxstrobe      (rxstrobe),
        .ch_0          (ch_0),
        .clear_overrun (clear_overrun),
        .pop           (sample_pop),
        .sample_head   (sample_head),
        .sample_level  (sample_level),
        .adctime       (adctime),
        .rx_overrun    (rx_overrun)
    );

    rx_cmd_path #(.CMD_DEPTH(CMD_DEPTH)) u_cmd_path (
        .rxclk         (rxclk),
        .reset         (reset),
        .rx_wr         (rx_wr),
        .rx_databus    (rx_databus),
        .rx_wr_done    (rx_wr_done),
        .adctime       (adctime),
        .pop           (cmd_pop),
        .cmd_ready     (cmd_ready),
        .cmd_head      (cmd_head),
        .cmd_level     (cmd_level),
        .cmd_stamp     (cmd_stamp),
        .rx_wr_enabled (rx_wr_enabled)
    );

    rx_packet_builder #(
        .PAYLOAD_WORDS (PAYLOAD_WORDS),
        .SAMPLE_DEPTH  (SAMPLE_DEPTH),
        .CMD_DEPTH     (CMD_DEPTH),
        .OUT_DEPTH     (OUT_DEPTH)
    ) u_packet_builder (
        .rxclk        (rxclk),
        .reset        (reset),
        .sample_head  (sample_head),
        .sample_level (sample_level),
        .sample_pop   (sample_pop),
        .cmd_ready    (cmd_ready),
        .cmd_head     (cmd_head),
        .cmd_level    (cmd_level),
        .cmd_stamp    (cmd_stamp),
        .cmd_pop      (cmd_pop),
        .out_level    (out_level),
        .out_push     (out_push),
        .out_data     (out_data)
    );

    // Packet words waiting for the host
    rx_fifo #(
        .DEPTH     (OUT_DEPTH),
        .payload_t (logic [15:0])
    ) u_out_fifo (
        .rxclk     (rxclk),
        .reset     (reset),
        .push      (out_push),
        .push_data (out_data),
        .pop       (out_pop),
        .head      (out_head),
        .level     (out_level),
        .full      (),
        .empty     ()
    );

    rx_apb_port #(
        .PAYLOAD_WORDS (PAYLOAD_WORDS),
        .OUT_DEPTH     (OUT_DEPTH)
    ) u_apb_port (
        .rxclk         (rxclk),
        .reset         (reset),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .out_head      (out_head),
        .out_level     (out_level),
        .out_pop       (out_pop),
        .rx_overrun    (rx_overrun),
        .clear_overrun (clear_overrun),
        .have_pkt_rdy  (have_pkt_rdy)
    );

endmodule

// ==== src/rx_buffer_pkg.sv ====
/* Sample entry, command word and packet header types,
   plus the packet framing constants */
package rx_buffer_pkg;

    // Header word and timestamp word ahead of every payload
    localparam int HDR_WORDS = 2;

    // One buffered sample with the strobe count it arrived on
    typedef struct packed {
        logic [15:0] timestamp;
        logic [15:0] data;
    } sample_entry_t;

    // One in-band command reply word
    typedef logic [15:0] cmd_word_t;

    // First word of each packet
    typedef struct packed {
        logic       is_cmd;
        logic [6:0] reserved;
        logic [7:0] payload_count;
    } pkt_header_t;

endpackage

// ==== src/rx_cmd_path.sv ====
/* Command path: reply FIFO, write gating and message timestamp */
`timescale 1ns/1ps

module rx_cmd_path #(
    parameter int CMD_DEPTH = 16
) (
    input  logic                           rxclk,
    input  logic                           reset,
    input  logic                           rx_wr,
    input  logic [15:0]                    rx_databus,
    input  logic                           rx_wr_done,
    input  logic [15:0]                    adctime,
    input  logic                           pop,
    output logic                           cmd_ready,
    output rx_buffer_pkg::cmd_word_t       cmd_head,
    output logic [$clog2(CMD_DEPTH):0]     cmd_level,
    output logic [15:0]                    cmd_stamp,
    output logic                           rx_wr_enabled
);
    import rx_buffer_pkg::*;

    logic empty;

    // Message is handed over once writes are closed
    assign cmd_ready = ~rx_wr_enabled & ~empty;

    always_ff @(posedge rxclk)
    begin
        if (reset)
            rx_wr_enabled <= 1'b1;
        else if (rx_wr_enabled && rx_wr_done)
            rx_wr_enabled <= 1'b0;
        else if (!rx_wr_enabled && empty)
            rx_wr_enabled <= 1'b1;
    end

    always_ff @(posedge rxclk)
    begin
        if (rx_wr_enabled && rx_wr_done)
            cmd_stamp <= adctime;
    end

    rx_fifo #(
        .DEPTH     (CMD_DEPTH),
        .payload_t (cmd_word_t)
    ) u_cmd_fifo (
        .rxclk     (rxclk),
        .reset     (reset),
        .push      (rx_wr & rx_wr_enabled),
        .push_data (rx_databus),
        .pop       (pop),
        .head      (cmd_head),
        .level     (cmd_level),
        .full      (),
        .empty     (empty)
    );

endmodule

// ==== src/rx_fifo.sv ====
/* Synchronous show-ahead FIFO with a type-parameterized payload */
`timescale 1ns/1ps

module rx_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [15:0]
) (
    input  logic                     rxclk,
    input  logic                     reset,
    input  logic                     push,
    input  payload_t                 push_data,
    input  logic                     pop,
    output payload_t                 head,
    output logic [$clog2(DEPTH):0]   level,
    output logic                     full,
    output logic                     empty
);
    localparam int AW = $clog2(DEPTH);
    localparam int LW = AW + 1;

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            do_push;
    logic            do_pop;

    assign full    = (level == LW'(DEPTH));
    assign empty   = (level == '0);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge rxclk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge rxclk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            // Pointers wrap explicitly so any depth works
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                level <= level + 1'b1;
            else if (do_pop && !do_push)
                level <= level - 1'b1;
        end
    end

endmodule

// ==== src/rx_packet_builder.sv ====
/* Packet builder: picks command or sample source and frames
   fixed-length timestamped packets into the output FIFO */
`timescale 1ns/1ps

module rx_packet_builder #(
    parameter int PAYLOAD_WORDS = 8,
    parameter int SAMPLE_DEPTH  = 32,
    parameter int CMD_DEPTH     = 16,
    parameter int OUT_DEPTH     = 64
) (
    input  logic                              rxclk,
    input  logic                              reset,
    input  rx_buffer_pkg::sample_entry_t      sample_head,
    input  logic [$clog2(SAMPLE_DEPTH):0]     sample_level,
    output logic                              sample_pop,
    input  logic                              cmd_ready,
    input  rx_buffer_pkg::cmd_word_t          cmd_head,
    input  logic [$clog2(CMD_DEPTH):0]        cmd_level,
    input  logic [15:0]                       cmd_stamp,
    output logic                              cmd_pop,
    input  logic [$clog2(OUT_DEPTH):0]        out_level,
    output logic                              out_push,
    output logic [15:0]                       out_data
);
    import rx_buffer_pkg::*;

    localparam int PKT_WORDS = HDR_WORDS + PAYLOAD_WORDS;

    typedef enum logic [1:0] {
        S_IDLE,
        S_HEADER,
        S_STAMP,
        S_PAYLOAD
    } state_t;

    state_t       state;
    logic [7:0]   idx;
    logic         is_cmd;
    logic [7:0]   count;
    logic [15:0]  stamp;
    logic         room;
    logic         sample_go;
    logic [7:0]   cmd_count;
    pkt_header_t  header;

    // Whole packet must fit before it is started
    assign room      = int'(out_level) <= OUT_DEPTH - PKT_WORDS;
    assign sample_go = int'(sample_level) >= PAYLOAD_WORDS;
    assign cmd_count = (int'(cmd_level) >= PAYLOAD_WORDS) ? 8'(PAYLOAD_WORDS)
                                                          : 8'(cmd_level);

    always_ff @(posedge rxclk)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            idx   <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (room && (cmd_ready || sample_go))
                        state <= S_HEADER;
                S_HEADER:
                    state <= S_STAMP;
                S_STAMP:
                begin
                    state <= S_PAYLOAD;
                    idx   <= '0;
                end
                S_PAYLOAD:
                begin
                    if (idx == 8'(PAYLOAD_WORDS - 1))
                        state <= S_IDLE;
                    idx <= idx + 8'd1;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // Source choice is taken in the last idle cycle, command first
    always_ff @(posedge rxclk)
    begin
        if (state == S_IDLE)
        begin
            is_cmd <= cmd_ready;
            count  <= cmd_ready ? cmd_count : 8'(PAYLOAD_WORDS);
            stamp  <= cmd_ready ? cmd_stamp : sample_head.timestamp;
        end
    end

    always_comb
    begin
        header               = '0;
        header.is_cmd        = is_cmd;
        header.payload_count = count;
        out_push   = 1'b0;
        out_data   = '0;
        sample_pop = 1'b0;
        cmd_pop    = 1'b0;
        case (state)
            S_HEADER:
            begin
                out_push = 1'b1;
                out_data = header;
            end
            S_STAMP:
            begin
                out_push = 1'b1;
                out_data = stamp;
            end
            S_PAYLOAD:
            begin
                out_push = 1'b1;
                if (!is_cmd)
                begin
                    out_data   = sample_head.data;
                    sample_pop = 1'b1;
                end
                else if (idx < count)
                begin
                    out_data = cmd_head;
                    cmd_pop  = 1'b1;
                end
                // Remaining command slots stay zero
            end
            default:
                out_push = 1'b0;
        endcase
    end

endmodule

// ==== src/rx_sample_path.sv ====
/* Sample path: strobe timestamp counter, sample FIFO, sticky overrun */
`timescale 1ns/1ps

module rx_sample_path #(
    parameter int SAMPLE_DEPTH = 32
) (
    input  logic                              rxclk,
    input  logic                              reset,
    input  logic                              rxstrobe,
    input  logic [15:0]                       ch_0,
    input  logic                              clear_overrun,
    input  logic                              pop,
    output rx_buffer_pkg::sample_entry_t      sample_head,
    output logic [$clog2(SAMPLE_DEPTH):0]     sample_level,
    output logic [15:0]                       adctime,
    output logic                              rx_overrun
);
    import rx_buffer_pkg::*;

    sample_entry_t  entry;
    logic           full;

    // Entry carries the count before this strobe's increment
    assign entry.timestamp = adctime;
    assign entry.data      = ch_0;

    always_ff @(posedge rxclk)
    begin
        if (reset)
            adctime <= '0;
        else if (rxstrobe)
            adctime <= adctime + 16'd1;
    end

    // A new overrun wins over a clear in the same cycle
    always_ff @(posedge rxclk)
    begin
        if (reset)
            rx_overrun <= 1'b0;
        else if (rxstrobe && full)
            rx_overrun <= 1'b1;
        else if (clear_overrun)
            rx_overrun <= 1'b0;
    end

    rx_fifo #(
        .DEPTH     (SAMPLE_DEPTH),
        .payload_t (sample_entry_t)
    ) u_sample_fifo (
        .rxclk     (rxclk),
        .reset     (reset),
        .push      (rxstrobe),
        .push_data (entry),
        .pop       (pop),
        .head      (sample_head),
        .level     (sample_level),
        .full      (full),
        .empty     ()
    );

endmodule

// ==== verification/rx_buffer_checker.sv ====
/* Concurrent assertions on the receive buffer top, bound to rx_buffer_inband */
`timescale 1ns/1ps

module rx_buffer_checker #(
    parameter int PAYLOAD_WORDS = 8,
    parameter int OUT_DEPTH     = 64
) (
    input logic                        rxclk,
    input logic                        reset,
    input logic                        out_push,
    input logic [$clog2(OUT_DEPTH):0]  out_level,
    input rx_apb_pkg::apb_req_t        apb_req,
    input rx_apb_pkg::apb_rsp_t        apb_rsp,
    input logic                        have_pkt_rdy,
    input logic                        rx_wr_enabled
);
    import rx_buffer_pkg::*;
    import rx_apb_pkg::*;

    no_push_when_full: assert property (@(posedge rxclk) disable iff (reset)
        out_push |-> (int'(out_level) < OUT_DEPTH))
        else $error("output FIFO pushed while full");

    // Error response only in the access of a data read that met an empty FIFO
    slverr_in_access: assert property (@(posedge rxclk) disable iff (reset)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable && !apb_req.pwrite
                             && apb_req.paddr == ADDR_DATA && $past(out_level) == '0))
        else $error("pslverr outside an empty data read access phase");

    wr_enabled_after_reset: assert property (@(posedge rxclk)
        reset |=> rx_wr_enabled)
        else $error("rx_wr_enabled low after reset");

    // Status bit 0 follows have_pkt_rdy and agrees with the level field
    pkt_rdy_matches_level: assert property (@(posedge rxclk) disable iff (reset)
        (apb_req.psel && apb_req.penable && !apb_req.pwrite
         && apb_req.paddr == ADDR_STATUS)
        |-> ((apb_rsp.prdata[0] == $past(have_pkt_rdy))
             && (apb_rsp.prdata[0]
                 == (int'(apb_rsp.prdata[15:8]) >= HDR_WORDS + PAYLOAD_WORDS))))
        else $error("have_pkt_rdy disagrees with the status level");

endmodule

bind rx_buffer_inband rx_buffer_checker #(
    .PAYLOAD_WORDS (PAYLOAD_WORDS),
    .OUT_DEPTH     (OUT_DEPTH)
) u_checker (
    .rxclk         (rxclk),
    .reset         (reset),
    .out_push      (out_push),
    .out_level     (out_level),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .have_pkt_rdy  (have_pkt_rdy),
    .rx_wr_enabled (rx_wr_enabled)
);

// ==== verification/tb_rx_buffer_inband.sv ====
/* Receive buffer testbench: clock and reset, seeded random stimulus,
   sample and command packet model, APB checks and watchdog */
`timescale 1ns/1ps

module tb_rx_buffer_inband;
    import rx_buffer_pkg::*;
    import rx_apb_pkg::*;

    localparam int PAYLOAD_WORDS = 8;
    localparam int SAMPLE_DEPTH  = 32;
    localparam int CMD_DEPTH     = 16;
    localparam int OUT_DEPTH     = 64;
    localparam int PKT_WORDS     = HDR_WORDS + PAYLOAD_WORDS;
    // Packets that fit in the output FIFO before the builder stalls
    localparam int STALL_PKTS    = OUT_DEPTH / PKT_WORDS;
    localparam int NUM_PHASES    = 5;
    localparam int PHASE_CYCLES  = 5000;

    logic        rxclk;
    logic        reset;
    logic        rxstrobe;
    logic [15:0] ch_0;
    logic        rx_wr;
    logic [15:0] rx_databus;
    logic        rx_wr_done;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        have_pkt_rdy;
    logic        rx_overrun;
    logic        rx_wr_enabled;

    integer      seed;
    int          errors;
    int          checks;
    int          strobe_cnt;
    int          accept_left;
    logic [31:0] samp_q[$];
    logic [15:0] msg_q[$];
    logic [15:0] msg_stamp;

    rx_buffer_inband #(
        .PAYLOAD_WORDS (PAYLOAD_WORDS),
        .SAMPLE_DEPTH  (SAMPLE_DEPTH),
        .CMD_DEPTH     (CMD_DEPTH),
        .OUT_DEPTH     (OUT_DEPTH)
    ) u_rx_buffer_inband (
        .rxclk         (rxclk),
        .reset         (reset),
        .rxstrobe      (rxstrobe),
        .ch_0          (ch_0),
        .rx_wr         (rx_wr),
        .rx_databus    (rx_databus),
        .rx_wr_done    (rx_wr_done),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .have_pkt_rdy  (have_pkt_rdy),
        .rx_overrun    (rx_overrun),
        .rx_wr_enabled (rx_wr_enabled)
    );

    initial
    begin
        rxclk = 1'b0;
        forever #5 rxclk = ~rxclk;
    end

    initial
    begin
        repeat (NUM_PHASES * PHASE_CYCLES) @(posedge rxclk);
        $display("Watchdog expired after %0d cycles, the run did not finish",
                 NUM_PHASES * PHASE_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] expected_status(input int level, input logic ovr);
        return {16'h0000, 8'(level), 6'b0, ovr, level >= PKT_WORDS};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge rxclk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(posedge rxclk);
        apb_req.penable <= 1'b1;
        @(negedge rxclk);
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        check_value("pready", 32'(apb_rsp.pready), 32'h1);
        @(posedge rxclk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge rxclk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge rxclk);
        apb_req.penable <= 1'b1;
        @(posedge rxclk);
        apb_req <= '0;
    endtask

    task automatic check_status(input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(ADDR_STATUS, data, err);
        check_value("status", data, exp);
        check_value("status pslverr", 32'(err), 32'h0);
        @(negedge rxclk);
        check_value("have_pkt_rdy", 32'(have_pkt_rdy), 32'(exp[0]));
    endtask

    task automatic read_data(output logic [15:0] word);
        logic [31:0] data;
        logic        err;
        apb_read(ADDR_DATA, data, err);
        check_value("data pslverr", 32'(err), 32'h0);
        word = data[15:0];
    endtask

    // Host waits for a whole packet, then a random pause
    task automatic wait_packet();
        @(negedge rxclk);
        while (!have_pkt_rdy)
            @(negedge rxclk);
        repeat (rand_below(4)) @(posedge rxclk);
    endtask

    task automatic strobe_samples(input int count);
        logic [15:0] value;
        repeat (count)
        begin
            value = 16'($random(seed));
            @(posedge rxclk);
            rxstrobe <= 1'b1;
            ch_0     <= value;
            // Entry stamp is the strobe count before this strobe
            if (accept_left > 0)
            begin
                samp_q.push_back({16'(strobe_cnt), value});
                accept_left--;
            end
            strobe_cnt++;
            @(posedge rxclk);
            rxstrobe <= 1'b0;
            repeat (rand_below(4)) @(posedge rxclk);
        end
    endtask

    task automatic send_message(input int len);
        logic [15:0] value;
        @(negedge rxclk);
        while (!rx_wr_enabled)
            @(negedge rxclk);
        repeat (len)
        begin
            value = 16'($random(seed));
            msg_q.push_back(value);
            @(posedge rxclk);
            rx_wr      <= 1'b1;
            rx_databus <= value;
        end
        @(posedge rxclk);
        rx_wr      <= 1'b0;
        rx_wr_done <= 1'b1;
        msg_stamp  = 16'(strobe_cnt);
        @(posedge rxclk);
        rx_wr_done <= 1'b0;
        // Stray words while writes are closed
        rx_wr      <= 1'b1;
        rx_databus <= 16'($random(seed));
        @(negedge rxclk);
        check_value("rx_wr_enabled", 32'(rx_wr_enabled), 32'h0);
        repeat (2) @(posedge rxclk);
        rx_wr <= 1'b0;
    endtask

    task automatic read_sample_packet();
        logic [15:0] word;
        pkt_header_t hdr;
        hdr               = '0;
        hdr.payload_count = 8'(PAYLOAD_WORDS);
        wait_packet();
        read_data(word);
        check_value("sample header", 32'(word), 32'(hdr));
        read_data(word);
        if (samp_q.size() < PAYLOAD_WORDS)
        begin
            errors++;
            $display("Sample packet stamped 0x%0h has no matching samples in the model", word);
            repeat (PAYLOAD_WORDS) read_data(word);
        end
        else
        begin
            check_value("sample stamp", 32'(word), 32'(samp_q[0][31:16]));
            for (int i = 0; i < PAYLOAD_WORDS; i++)
            begin
                read_data(word);
                check_value("sample data", 32'(word), 32'(samp_q[0][15:0]));
                void'(samp_q.pop_front());
            end
        end
    endtask

    task automatic read_cmd_packets();
        logic [15:0] word;
        pkt_header_t hdr;
        int          n;
        while (msg_q.size() > 0)
        begin
            n                 = (msg_q.size() < PAYLOAD_WORDS) ? msg_q.size() : PAYLOAD_WORDS;
            hdr               = '0;
            hdr.is_cmd        = 1'b1;
            hdr.payload_count = 8'(n);
            wait_packet();
            read_data(word);
            check_value("cmd header", 32'(word), 32'(hdr));
            read_data(word);
            check_value("cmd stamp", 32'(word), 32'(msg_stamp));
            for (int i = 0; i < PAYLOAD_WORDS; i++)
            begin
                read_data(word);
                if (i < n)
                    check_value("cmd word", 32'(word), 32'(msg_q.pop_front()));
                else
                    check_value("cmd padding", 32'(word), 32'h0);
            end
        end
    endtask

    initial
    begin
        logic [31:0] data;
        logic        err;
        seed        = 50;
        errors      = 0;
        checks      = 0;
        strobe_cnt  = 0;
        accept_left = 32'h7fff_ffff;
        reset       = 1'b1;
        rxstrobe    = 1'b0;
        ch_0        = '0;
        rx_wr       = 1'b0;
        rx_databus  = '0;
        rx_wr_done  = 1'b0;
        apb_req     = '0;
        repeat (16) @(posedge rxclk);
        reset <= 1'b0;

        // Reset state
        @(negedge rxclk);
        check_value("rx_overrun", 32'(rx_overrun), 32'h0);
        check_value("have_pkt_rdy", 32'(have_pkt_rdy), 32'h0);
        check_value("rx_wr_enabled", 32'(rx_wr_enabled), 32'h1);
        check_value("pslverr", 32'(apb_rsp.pslverr), 32'h0);
        check_value("prdata", apb_rsp.prdata, 32'h0);
        check_status(expected_status(0, 1'b0));
        apb_read(ADDR_DATA, data, err);
        check_value("empty data", data, 32'h0);
        check_value("empty pslverr", 32'(err), 32'h1);

        // Sample packets read while strobes arrive
        fork
            strobe_samples(4 * PAYLOAD_WORDS);
            repeat (4) read_sample_packet();
        join
        check_status(expected_status(0, 1'b0));

        // Command messages, some split over two packets
        repeat (4)
        begin
            send_message(1 + rand_below(12));
            read_cmd_packets();
            @(negedge rxclk);
            check_value("rx_wr_enabled", 32'(rx_wr_enabled), 32'h1);
        end

        // Stalled builder with a sample payload and a message both waiting
        strobe_samples(STALL_PKTS * PAYLOAD_WORDS + PAYLOAD_WORDS);
        send_message(1 + rand_below(12));
        repeat (20) @(posedge rxclk);
        check_status(expected_status(STALL_PKTS * PKT_WORDS, 1'b0));
        repeat (STALL_PKTS) read_sample_packet();
        read_cmd_packets();
        read_sample_packet();
        check_status(expected_status(0, 1'b0));

        // Overrun with the host idle, then recovery
        accept_left = STALL_PKTS * PAYLOAD_WORDS + SAMPLE_DEPTH;
        strobe_samples(accept_left + 2 * PAYLOAD_WORDS);
        repeat (20) @(posedge rxclk);
        @(negedge rxclk);
        check_value("rx_overrun", 32'(rx_overrun), 32'h1);
        check_status(expected_status(STALL_PKTS * PKT_WORDS, 1'b1));
        repeat (STALL_PKTS + SAMPLE_DEPTH / PAYLOAD_WORDS) read_sample_packet();
        check_status(expected_status(0, 1'b1));
        apb_write(ADDR_CTRL, 32'h1);
        check_status(expected_status(0, 1'b0));
        check_value("rx_overrun", 32'(rx_overrun), 32'h0);
        accept_left = 32'h7fff_ffff;
        fork
            strobe_samples(PAYLOAD_WORDS);
            read_sample_packet();
        join
        check_status(expected_status(0, 1'b0));

        $display("Closing summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
